// ==== src/alu_settings.svh ====
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// operand and result width
`define ALU_XLEN 32

// transform length
`define FFT_POINTS 8

// fixed point samples, low bits are the fraction
`define FFT_FRAC_BITS 6

// 1/sqrt(2) scaled by 2^FFT_FRAC_BITS
`define FFT_WN 45

// rv32 shifts use the low five bits of src2
`define ALU_SHAMT_BITS 5

`endif

// ==== src/alu_pkg.sv ====
`default_nettype none

`include "alu_settings.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0]       word_t;
    typedef logic [2*`ALU_XLEN-1:0]     dword_t;
    typedef logic [$clog2(`FFT_POINTS)-1:0] sample_idx_t;

    // integer ops first, op_auipc closes the integer group
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_mul,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_lui,
        op_auipc,
        op_fft_load,
        op_fft_cal1,
        op_fft_cal2,
        op_fft_cal3,
        op_fft_export
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        sample_idx_t idx;
        logic        imag;
    } alu_cmd_t;

    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

endpackage

`default_nettype wire

// ==== src/int_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "alu_settings.svh"

module int_alu import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    input  alu_cmd_t cmd,
    input  word_t    src1,
    input  word_t    src2,
    input  word_t    curr_pc,
    output logic     int_valid,
    output word_t    int_result,
    output logic     zero
);

    logic [`ALU_SHAMT_BITS-1:0] shamt;
    word_t                      result_d;
    logic                       zero_d;
    logic                       valid_d;

    assign shamt = src2[`ALU_SHAMT_BITS-1:0];

    always_comb begin
        result_d = '0;
        zero_d   = 1'b0;
        valid_d  = 1'b1;
        case (cmd.op)
            op_add:   result_d = src1 + src2;
            op_sub:   result_d = src1 - src2;
            // low half is the same for signed and unsigned
            op_mul:   result_d = src1 * src2;
            op_xor:   result_d = src1 ^ src2;
            op_or:    result_d = src1 | src2;
            op_and:   result_d = src1 & src2;
            op_sll:   result_d = src1 << shamt;
            op_srl:   result_d = src1 >> shamt;
            op_sra:   result_d = word_t'($signed(src1) >>> shamt);
            op_slt:   result_d = word_t'($signed(src1) < $signed(src2));
            op_sltu:  result_d = word_t'(src1 < src2);
            op_beq:   zero_d = (src1 == src2);
            op_bne:   zero_d = (src1 != src2);
            op_blt:   zero_d = ($signed(src1) < $signed(src2));
            op_bge:   zero_d = ($signed(src1) >= $signed(src2));
            op_lui:   result_d = src2;
            op_auipc: result_d = curr_pc + src2;
            // fft commands are handled elsewhere
            default:  valid_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            int_valid <= 1'b0;
            zero      <= 1'b0;
        end else begin
            int_valid <= cmd_valid & valid_d;
            zero      <= cmd_valid & zero_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && valid_d) begin
            int_result <= result_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/fft_sample_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "alu_settings.svh"

module fft_sample_bank import alu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    input  alu_cmd_t                  cmd,
    input  word_t                     src1,
    input  word_t                     src2,
    output cplx_t [`FFT_POINTS-1:0]   samples
);

    logic load_en;

    assign load_en = cmd_valid && (cmd.op == op_fft_load);

    // src1 carries the real part, src2 the imaginary part
    always_ff @(posedge clk) begin
        if (rst) begin
            samples <= '0;
        end else if (load_en) begin
            samples[cmd.idx].re <= src1;
            samples[cmd.idx].im <= src2;
        end
    end

endmodule

`default_nettype wire

// ==== src/fft_butterfly.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "alu_settings.svh"

module fft_butterfly import alu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  alu_cmd_t                cmd,
    input  cplx_t [`FFT_POINTS-1:0] samples,
    output logic                    fft_valid,
    output word_t                   fft_result
);

    localparam int HALF = `FFT_POINTS / 2;

    cplx_t [`FFT_POINTS-1:0] s1;
    cplx_t [`FFT_POINTS-1:0] s2;
    cplx_t [`FFT_POINTS-1:0] s3;
    cplx_t [`FFT_POINTS-1:0] s1_d;
    cplx_t [`FFT_POINTS-1:0] s2_d;
    cplx_t [`FFT_POINTS-1:0] s3_d;

    function automatic dword_t sext(input word_t w);
        return {{`ALU_XLEN{w[`ALU_XLEN-1]}}, w};
    endfunction

    // multiply by wn, drop the fraction bits, keep the low word
    function automatic word_t wn_scale(input dword_t v);
        dword_t prod;
        prod = dword_t'($signed(v) * $signed(dword_t'(`FFT_WN)));
        prod = dword_t'($signed(prod) >>> `FFT_FRAC_BITS);
        return prod[`ALU_XLEN-1:0];
    endfunction

    // W^k * v for the 8 point transform
    function automatic cplx_t twiddle(input cplx_t v, input logic [1:0] k);
        dword_t sum;
        dword_t diff;
        cplx_t  t;
        sum  = sext(v.re) + sext(v.im);
        diff = sext(v.im) - sext(v.re);
        case (k)
            2'd0: t = v;
            2'd1: begin
                t.re = wn_scale(sum);
                t.im = wn_scale(diff);
            end
            2'd2: begin
                t.re = v.im;
                t.im = '0 - v.re;
            end
            default: begin
                t.re = wn_scale(diff);
                t.im = wn_scale('0 - sum);
            end
        endcase
        return t;
    endfunction

    always_comb begin
        cplx_t tw;
        // stage 1, inputs taken in bit reversed pairs
        for (int m = 0; m < HALF; m++) begin
            s1_d[2*m].re   = samples[{m[0], m[1]}].re + samples[{m[0], m[1]} + HALF].re;
            s1_d[2*m].im   = samples[{m[0], m[1]}].im + samples[{m[0], m[1]} + HALF].im;
            s1_d[2*m+1].re = samples[{m[0], m[1]}].re - samples[{m[0], m[1]} + HALF].re;
            s1_d[2*m+1].im = samples[{m[0], m[1]}].im - samples[{m[0], m[1]} + HALF].im;
        end
        // stage 2, each half on its own, d is rotated by -j
        for (int h = 0; h < `FFT_POINTS; h += HALF) begin
            s2_d[h].re   = s1[h].re + s1[h+2].re;
            s2_d[h].im   = s1[h].im + s1[h+2].im;
            s2_d[h+2].re = s1[h].re - s1[h+2].re;
            s2_d[h+2].im = s1[h].im - s1[h+2].im;
            s2_d[h+1].re = s1[h+1].re + s1[h+3].im;
            s2_d[h+1].im = s1[h+1].im - s1[h+3].re;
            s2_d[h+3].re = s1[h+1].re - s1[h+3].im;
            s2_d[h+3].im = s1[h+1].im + s1[h+3].re;
        end
        // stage 3
        for (int k = 0; k < HALF; k++) begin
            tw = twiddle(s2[k+HALF], 2'(k));
            s3_d[k].re      = s2[k].re + tw.re;
            s3_d[k].im      = s2[k].im + tw.im;
            s3_d[k+HALF].re = s2[k].re - tw.re;
            s3_d[k+HALF].im = s2[k].im - tw.im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1        <= '0;
            s2        <= '0;
            s3        <= '0;
            fft_valid <= 1'b0;
        end else begin
            fft_valid <= cmd_valid && (cmd.op == op_fft_export);
            if (cmd_valid) begin
                case (cmd.op)
                    op_fft_cal1: s1 <= s1_d;
                    op_fft_cal2: s2 <= s2_d;
                    op_fft_cal3: s3 <= s3_d;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && (cmd.op == op_fft_export)) begin
            fft_result <= cmd.imag ? s3[cmd.idx].im : s3[cmd.idx].re;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_top import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    input  alu_cmd_t cmd,
    input  word_t    src1,
    input  word_t    src2,
    input  word_t    curr_pc,
    output logic     result_valid,
    output word_t    result,
    output logic     zero
);

    logic                    int_valid;
    word_t                   int_result;
    logic                    fft_valid;
    word_t                   fft_result;
    cplx_t [`FFT_POINTS-1:0] samples;

    int_alu int_alu_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .src1       (src1),
        .src2       (src2),
        .curr_pc    (curr_pc),
        .int_valid  (int_valid),
        .int_result (int_result),
        .zero       (zero)
    );

    fft_sample_bank fft_sample_bank_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .src1      (src1),
        .src2      (src2),
        .samples   (samples)
    );

    fft_butterfly fft_butterfly_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .samples    (samples),
        .fft_valid  (fft_valid),
        .fft_result (fft_result)
    );

    // the two valids are never high together
    assign result_valid = int_valid | fft_valid;
    assign result       = int_valid ? int_result : fft_result;

endmodule

`default_nettype wire

// ==== testbench/alu_assert.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_assert import alu_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     cmd_valid,
    input alu_cmd_t cmd,
    input logic     result_valid,
    input logic     zero
);

    logic has_result;

    // load and the three cal steps only update internal state
    assign has_result = cmd_valid && !(cmd.op inside {op_fft_load, op_fft_cal1,
                                                      op_fft_cal2, op_fft_cal3});

    valid_after_strobe: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> result_valid == $past(has_result))
        else $error("result_valid does not follow the command strobe");

    zero_needs_valid: assert property (@(posedge clk) zero |-> result_valid)
        else $error("zero is high without result_valid");

    quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !result_valid && !zero)
        else $error("outputs valid while in reset");

endmodule

bind alu_top alu_assert alu_assert_i (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .result_valid (result_valid),
    .zero         (zero)
);

`default_nettype wire

// ==== testbench/alu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_INT_CMDS = 200;
    localparam int NUM_FFT_SETS = 5;
    // 8 loads, 3 cals, 16 exports
    localparam int FFT_SET_CMDS = 27;
    localparam int TOTAL_CMDS   = NUM_INT_CMDS + 64 + 8 + (NUM_FFT_SETS + 1) * FFT_SET_CMDS + 16;
    localparam int WATCHDOG_NS  = (TOTAL_CMDS + 400) * CLK_PERIOD;

    typedef struct packed {
        word_t       result;
        logic        zero;
        logic [31:0] due;
    } expect_t;

    typedef cplx_t [`FFT_POINTS-1:0]   cplx_vec_t;
    typedef word_t [2*`FFT_POINTS-1:0] export_vec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_valid;
    alu_cmd_t    cmd;
    word_t       src1;
    word_t       src2;
    word_t       curr_pc;
    logic        result_valid;
    word_t       result;
    logic        zero;
    logic [31:0] cycle = '0;
    expect_t     exp_q[$];
    int          error_count = 0;
    int          check_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    alu_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .src1         (src1),
        .src2         (src2),
        .curr_pc      (curr_pc),
        .result_valid (result_valid),
        .result       (result),
        .zero         (zero)
    );

    function automatic expect_t ref_int(input alu_op_e opc, input word_t a, input word_t b,
                                        input word_t pc);
        expect_t e;
        int      sa;
        int      sb;
        sa = a;
        sb = b;
        e  = '0;
        case (opc)
            op_add:   e.result = a + b;
            op_sub:   e.result = a - b;
            op_mul:   e.result = a * b;
            op_xor:   e.result = a ^ b;
            op_or:    e.result = a | b;
            op_and:   e.result = a & b;
            op_sll:   e.result = a << b[`ALU_SHAMT_BITS-1:0];
            op_srl:   e.result = a >> b[`ALU_SHAMT_BITS-1:0];
            op_sra:   e.result = word_t'(sa >>> b[`ALU_SHAMT_BITS-1:0]);
            op_slt:   e.result = (sa < sb) ? 32'd1 : 32'd0;
            op_sltu:  e.result = (a < b) ? 32'd1 : 32'd0;
            op_beq:   e.zero = (a == b);
            op_bne:   e.zero = (a != b);
            op_blt:   e.zero = (sa < sb);
            op_bge:   e.zero = !(sa < sb);
            op_lui:   e.result = b;
            op_auipc: e.result = pc + b;
            default:  e = '0;
        endcase
        return e;
    endfunction

    // fixed point multiply by 1/sqrt(2)
    function automatic longint wn_mul(input longint v);
        return (v * `FFT_WN) >>> `FFT_FRAC_BITS;
    endfunction

    function automatic export_vec_t ref_fft(input cplx_vec_t x);
        int          xr[8];
        int          xi[8];
        int          ar[8];
        int          ai[8];
        int          br[8];
        int          bi[8];
        int          tr;
        int          ti;
        int          p;
        longint      sum;
        longint      dif;
        export_vec_t y;
        for (int n = 0; n < 8; n++) begin
            xr[n] = x[n].re;
            xi[n] = x[n].im;
        end
        // pairs (0,4) (2,6) (1,5) (3,7)
        for (int m = 0; m < 4; m++) begin
            p = (m == 1) ? 2 : ((m == 2) ? 1 : m);
            ar[2*m]   = xr[p] + xr[p+4];
            ai[2*m]   = xi[p] + xi[p+4];
            ar[2*m+1] = xr[p] - xr[p+4];
            ai[2*m+1] = xi[p] - xi[p+4];
        end
        for (int h = 0; h < 8; h += 4) begin
            br[h]   = ar[h] + ar[h+2];
            bi[h]   = ai[h] + ai[h+2];
            br[h+2] = ar[h] - ar[h+2];
            bi[h+2] = ai[h] - ai[h+2];
            // -j*d is (d.im, -d.re)
            br[h+1] = ar[h+1] + ai[h+3];
            bi[h+1] = ai[h+1] - ar[h+3];
            br[h+3] = ar[h+1] - ai[h+3];
            bi[h+3] = ai[h+1] + ar[h+3];
        end
        for (int k = 0; k < 4; k++) begin
            sum = longint'(br[k+4]) + longint'(bi[k+4]);
            dif = longint'(bi[k+4]) - longint'(br[k+4]);
            case (k)
                0: begin
                    tr = br[k+4];
                    ti = bi[k+4];
                end
                1: begin
                    tr = int'(wn_mul(sum));
                    ti = int'(wn_mul(dif));
                end
                2: begin
                    tr = bi[k+4];
                    ti = -br[k+4];
                end
                default: begin
                    tr = int'(wn_mul(dif));
                    ti = int'(wn_mul(-sum));
                end
            endcase
            y[2*k]       = word_t'(br[k] + tr);
            y[2*k+1]     = word_t'(bi[k] + ti);
            y[2*(k+4)]   = word_t'(br[k] - tr);
            y[2*(k+4)+1] = word_t'(bi[k] - ti);
        end
        return y;
    endfunction

    function automatic alu_cmd_t make_cmd(input alu_op_e opc, input int idx, input logic imag);
        alu_cmd_t c;
        c.op   = opc;
        c.idx  = sample_idx_t'(idx);
        c.imag = imag;
        return c;
    endfunction

    function automatic word_t corner(input int n);
        case (n % 5)
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            default: return 32'h0000_0001;
        endcase
    endfunction

    function automatic cplx_vec_t random_samples();
        cplx_vec_t x;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            x[n].re = word_t'(int'($urandom_range(8192, 0)) - 4096);
            x[n].im = word_t'(int'($urandom_range(8192, 0)) - 4096);
        end
        return x;
    endfunction

    task automatic issue(input alu_cmd_t c, input word_t a, input word_t b, input word_t pc,
                         input logic has_result, input expect_t e);
        expect_t pending;
        pending = e;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        src1      <= a;
        src2      <= b;
        curr_pc   <= pc;
        if (has_result) begin
            // sampled on the next edge and visible after the one that follows
            pending.due = cycle + 32'd2;
            exp_q.push_back(pending);
        end
    endtask

    task automatic int_cmd(input alu_op_e opc, input word_t a, input word_t b, input word_t pc);
        issue(make_cmd(opc, 0, 1'b0), a, b, pc, 1'b1, ref_int(opc, a, b, pc));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic run_fft(input cplx_vec_t x, input logic gaps);
        export_vec_t y;
        expect_t     e;
        y = ref_fft(x);
        for (int n = 0; n < `FFT_POINTS; n++) begin
            issue(make_cmd(op_fft_load, n, 1'b0), x[n].re, x[n].im, '0, 1'b0, '0);
        end
        if (gaps) begin
            idle(2);
        end
        issue(make_cmd(op_fft_cal1, 0, 1'b0), '0, '0, '0, 1'b0, '0);
        issue(make_cmd(op_fft_cal2, 0, 1'b0), '0, '0, '0, 1'b0, '0);
        issue(make_cmd(op_fft_cal3, 0, 1'b0), '0, '0, '0, 1'b0, '0);
        if (gaps) begin
            idle(2);
        end
        for (int i = 0; i < 2 * `FFT_POINTS; i++) begin
            e        = '0;
            e.result = y[i];
            issue(make_cmd(op_fft_export, i / 2, i[0]), '0, '0, '0, 1'b1, e);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        idle(3);
        if (exp_q.size() != 0) begin
            $display("%0t: %0d expected results never arrived in %s", $time, exp_q.size(), name);
            error_count++;
            exp_q.delete();
        end
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("%0t: result_valid raised with no result pending", $time);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                check_count++;
                if (cycle != e.due) begin
                    $display("%0t: result came in cycle %0d instead of cycle %0d",
                             $time, cycle, e.due);
                    error_count++;
                end
                if (result !== e.result) begin
                    $display("** Error at %0t: result expected %h, got %h",
                             $time, e.result, result);
                    error_count++;
                end
                if (zero !== e.zero) begin
                    $display("** Error at %0t: zero expected %b, got %b", $time, e.zero, zero);
                    error_count++;
                end
            end
        end
    end

    initial begin
        int        errors_before;
        word_t     a;
        word_t     b;
        cplx_vec_t x;
        rst       = 1'b1;
        // an equal beq held through reset must not reach the outputs
        cmd_valid = 1'b1;
        cmd       = make_cmd(op_beq, 0, 1'b0);
        src1      = '0;
        src2      = '0;
        curr_pc   = '0;
        void'($urandom(10265));
        repeat (10) @(posedge clk);
        rst       <= 1'b0;
        cmd_valid <= 1'b0;

        errors_before = error_count;
        @(negedge clk);
        check_count++;
        if (result_valid !== 1'b0) begin
            $display("** Error at %0t: result_valid expected 0, got %b", $time, result_valid);
            error_count++;
        end
        if (zero !== 1'b0) begin
            $display("** Error at %0t: zero expected 0, got %b", $time, zero);
            error_count++;
        end
        finish_test("reset", errors_before);

        errors_before = error_count;
        for (int i = 0; i < NUM_INT_CMDS; i++) begin
            int_cmd(alu_op_e'($urandom_range(10, 0)), $urandom, $urandom, $urandom);
        end
        finish_test("integer ops", errors_before);

        // equal pairs and sign boundaries first, then random pairs
        errors_before = error_count;
        for (int opn = 0; opn < 4; opn++) begin
            for (int n = 0; n < 16; n++) begin
                a = (n < 8) ? corner(n) : $urandom;
                b = (n < 8) ? corner(n + n / 2) : ((n % 3 == 0) ? a : $urandom);
                int_cmd(alu_op_e'(int'(op_beq) + opn), a, b, '0);
            end
        end
        finish_test("branch compares", errors_before);

        errors_before = error_count;
        for (int n = 0; n < 4; n++) begin
            int_cmd(op_lui, $urandom, $urandom & 32'hffff_f000, $urandom);
            int_cmd(op_auipc, $urandom, $urandom & 32'hffff_f000, $urandom & 32'hffff_fffc);
        end
        finish_test("lui and auipc", errors_before);

        errors_before = error_count;
        for (int s = 0; s < NUM_FFT_SETS; s++) begin
            x = random_samples();
            run_fft(x, 1'b1);
        end
        finish_test("fft sets", errors_before);

        errors_before = error_count;
        x = random_samples();
        run_fft(x, 1'b0);
        for (int i = 0; i < 16; i++) begin
            int_cmd(alu_op_e'($urandom_range(16, 0)), $urandom, $urandom, $urandom);
        end
        finish_test("back to back stream", errors_before);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/alu_pkg.sv
src/int_alu.sv
src/fft_sample_bank.sv
src/fft_butterfly.sv
src/alu_top.sv
testbench/alu_assert.sv
testbench/alu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f files.f
./obj_dir/Valu_tb | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
